// File: design/core_pkg.sv
package core_pkg;

    // ========================================================================
    // Widths and counts
    // ========================================================================
    localparam int XLEN          = 32;
    localparam int NUM_REGS      = 32;
    localparam int MAX_IN_FLIGHT = 2;     // Execute plus writeback

    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_addr_t;

    // RV32I encodings that the core accepts
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;  // SUB, SRA, SRAI

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SRA = 4'd7
    } alu_op_e;

    // ========================================================================
    // Stage payloads
    // ========================================================================
    typedef struct packed {
        alu_op_e   alu_op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      use_imm;     // Operand b from imm, not rs2
        word_t     imm;
        logic      reg_write;
        logic      illegal;
    } decoded_t;

    typedef struct packed {
        alu_op_e   alu_op;
        word_t     op_a;
        word_t     op_b;
        reg_addr_t rd;
        logic      reg_write;
        logic      illegal;
    } ex_payload_t;

    typedef struct packed {
        reg_addr_t rd;
        word_t     value;
        logic      reg_write;
        logic      illegal;
    } retire_t;

endpackage

// File: design/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  core_pkg::instr_t   instr,
    output core_pkg::decoded_t decoded
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_e    op;
    logic       bad;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Opcode, funct7 and funct3 to ALU operation
    always_comb begin
        op  = ALU_ADD;
        bad = 1'b0;
        if (opcode == OPCODE_OP) begin
            case ({funct7, funct3})
                {FUNCT7_BASE, 3'b000}: op = ALU_ADD;
                {FUNCT7_ALT,  3'b000}: op = ALU_SUB;
                {FUNCT7_BASE, 3'b111}: op = ALU_AND;
                {FUNCT7_BASE, 3'b110}: op = ALU_OR;
                {FUNCT7_BASE, 3'b100}: op = ALU_XOR;
                {FUNCT7_BASE, 3'b001}: op = ALU_SLL;
                {FUNCT7_BASE, 3'b101}: op = ALU_SRL;
                {FUNCT7_ALT,  3'b101}: op = ALU_SRA;
                default:               bad = 1'b1;  // SLT, SLTU, odd funct7
            endcase
        end else if (opcode == OPCODE_OP_IMM) begin
            case (funct3)
                3'b000: op = ALU_ADD;
                3'b111: op = ALU_AND;
                3'b110: op = ALU_OR;
                3'b100: op = ALU_XOR;
                3'b001: begin
                    op  = ALU_SLL;
                    bad = (funct7 != FUNCT7_BASE);  // Shift amount above 31
                end
                3'b101: begin
                    if (funct7 == FUNCT7_BASE) begin
                        op = ALU_SRL;
                    end else if (funct7 == FUNCT7_ALT) begin
                        op = ALU_SRA;
                    end else begin
                        bad = 1'b1;
                    end
                end
                default: bad = 1'b1;
            endcase
        end else begin
            bad = 1'b1;
        end
    end

    assign decoded.alu_op    = op;
    assign decoded.rs1       = instr[19:15];
    assign decoded.rs2       = instr[24:20];
    assign decoded.rd        = instr[11:7];
    assign decoded.use_imm   = (opcode == OPCODE_OP_IMM);
    assign decoded.imm       = {{(XLEN-12){instr[31]}}, instr[31:20]};  // I-type, signed
    assign decoded.reg_write = !bad;
    assign decoded.illegal   = bad;

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                clk,
    input  logic                reset_n,
    input  core_pkg::reg_addr_t read_addr_1,
    input  core_pkg::reg_addr_t read_addr_2,
    output core_pkg::word_t     read_data_1,
    output core_pkg::word_t     read_data_2,
    input  logic                write_enable,
    input  core_pkg::reg_addr_t write_addr,
    input  core_pkg::word_t     write_data
);
    import core_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && (write_addr != '0)) begin  // x0 stays zero
            regs[write_addr] <= write_data;
        end
    end

    // Asynchronous reads, x0 forced
    assign read_data_1 = (read_addr_1 == '0) ? '0 : regs[read_addr_1];
    assign read_data_2 = (read_addr_2 == '0) ? '0 : regs[read_addr_2];

endmodule

// File: design/alu.sv
`timescale 1ns/1ps

module alu (
    input  core_pkg::alu_op_e op,
    input  core_pkg::word_t   a,
    input  core_pkg::word_t   b,
    output core_pkg::word_t   result
);
    import core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];  // RV32 shifts use 5 bits

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLL: result = a << shamt;
            ALU_SRL: result = a >> shamt;
            ALU_SRA: result = word_t'($signed(a) >>> shamt);  // Sign fill
            default: result = '0;
        endcase
    end

endmodule

// File: design/pipe_stage.sv
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // Free when empty or draining this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

// File: design/hazard_control.sv
`timescale 1ns/1ps

module hazard_control (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                in_valid,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    input  logic                uses_rs2,
    input  logic                ex_pending,
    input  logic                wb_pending,
    input  core_pkg::reg_addr_t ex_rd,
    input  core_pkg::reg_addr_t wb_rd,
    input  logic                stage_ready,
    input  logic                retire,
    output logic                in_ready,
    output logic                issue,
    output logic                idle
);
    import core_pkg::*;

    localparam int CNT_W = $clog2(MAX_IN_FLIGHT + 1);

    logic             armed;        // Low until first edge after reset
    logic [CNT_W-1:0] in_flight;
    logic             rs1_hit;
    logic             rs2_hit;

    // No forwarding, so any pending write to a source blocks issue
    assign rs1_hit = (rs1 != '0) &&
                     ((ex_pending && (ex_rd == rs1)) || (wb_pending && (wb_rd == rs1)));
    assign rs2_hit = uses_rs2 && (rs2 != '0) &&
                     ((ex_pending && (ex_rd == rs2)) || (wb_pending && (wb_rd == rs2)));

    assign in_ready = armed && stage_ready && !rs1_hit && !rs2_hit;
    assign issue    = in_valid && in_ready;
    assign idle     = (in_flight == '0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            armed     <= 1'b0;
            in_flight <= '0;
        end else begin
            armed <= 1'b1;
            case ({issue, retire})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;  // Both or neither
            endcase
        end
    end

endmodule

// File: design/alu_core_top.sv
`timescale 1ns/1ps

module alu_core_top (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              in_valid,
    output logic              in_ready,
    input  core_pkg::instr_t  in_instr,
    output logic              out_valid,
    input  logic              out_ready,
    output core_pkg::retire_t out_retire,
    output logic              idle
);
    import core_pkg::*;

    decoded_t    dec;
    word_t       rd_data_1;
    word_t       rd_data_2;
    ex_payload_t ex_in;
    ex_payload_t ex_out;
    logic        ex_valid;
    logic        ex_ready;
    logic        issue;
    word_t       alu_result;
    retire_t     wb_in;
    logic        wb_ready;
    logic        retire_fire;

    // ========================================================================
    // Decode and register read
    // ========================================================================
    instr_decoder u_decoder (
        .instr   (in_instr),
        .decoded (dec)
    );

    assign retire_fire = out_valid && out_ready;

    reg_file u_reg_file (
        .clk          (clk),
        .reset_n      (reset_n),
        .read_addr_1  (dec.rs1),
        .read_addr_2  (dec.rs2),
        .read_data_1  (rd_data_1),
        .read_data_2  (rd_data_2),
        .write_enable (retire_fire && out_retire.reg_write),  // Write at retire
        .write_addr   (out_retire.rd),
        .write_data   (out_retire.value)
    );

    hazard_control u_hazard (
        .clk         (clk),
        .reset_n     (reset_n),
        .in_valid    (in_valid),
        .rs1         (dec.rs1),
        .rs2         (dec.rs2),
        .uses_rs2    (!dec.use_imm),
        .ex_pending  (ex_valid && ex_out.reg_write),
        .wb_pending  (out_valid && out_retire.reg_write),
        .ex_rd       (ex_out.rd),
        .wb_rd       (out_retire.rd),
        .stage_ready (ex_ready),
        .retire      (retire_fire),
        .in_ready    (in_ready),
        .issue       (issue),
        .idle        (idle)
    );

    assign ex_in.alu_op    = dec.alu_op;
    assign ex_in.op_a      = rd_data_1;
    assign ex_in.op_b      = dec.use_imm ? dec.imm : rd_data_2;
    assign ex_in.rd        = dec.rd;
    assign ex_in.reg_write = dec.reg_write;
    assign ex_in.illegal   = dec.illegal;

    // ========================================================================
    // Execute and writeback
    // ========================================================================
    pipe_stage #(.payload_t(ex_payload_t)) u_ex_stage (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (issue),
        .in_ready  (ex_ready),
        .in_data   (ex_in),
        .out_valid (ex_valid),
        .out_ready (wb_ready),
        .out_data  (ex_out)
    );

    alu u_alu (
        .op     (ex_out.alu_op),
        .a      (ex_out.op_a),
        .b      (ex_out.op_b),
        .result (alu_result)
    );

    assign wb_in.rd        = ex_out.rd;
    assign wb_in.value     = alu_result;
    assign wb_in.reg_write = ex_out.reg_write;
    assign wb_in.illegal   = ex_out.illegal;

    pipe_stage #(.payload_t(retire_t)) u_wb_stage (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (ex_valid),
        .in_ready  (wb_ready),
        .in_data   (wb_in),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_retire)
    );

endmodule

// File: verif/alu_core_assertions.sv
`timescale 1ns/1ps

module alu_core_assertions (
    input logic              clk,
    input logic              reset_n,
    input logic              in_ready,
    input logic              out_valid,
    input logic              out_ready,
    input core_pkg::retire_t out_retire
);

    // A stalled record keeps its contents
    stall_hold: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && !out_ready |=> out_valid && $stable(out_retire))
        else $error("out_retire changed while the output was stalled");

    ready_in_reset: assert property (@(posedge clk) !reset_n |-> !in_ready)
        else $error("in_ready high during reset");

    // Illegal instructions never touch the register file
    no_illegal_write: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid |-> !(out_retire.illegal && out_retire.reg_write))
        else $error("illegal retire record has reg_write set");

endmodule

bind alu_core_top alu_core_assertions u_assertions (
    .clk        (clk),
    .reset_n    (reset_n),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_retire (out_retire)
);

// File: verif/tb_alu_core.sv
`timescale 1ns/1ps

module tb_alu_core;
    import core_pkg::*;

    localparam int          SEED           = 51172;
    localparam int          TIMEOUT_CYCLES = 20000;
    // R-type op table, entry k at bits [3k+2:3k]: ADD SUB AND OR XOR SLL SRL SRA
    localparam logic [23:0] R_F3  = {3'b101, 3'b101, 3'b001, 3'b100,
                                     3'b110, 3'b111, 3'b000, 3'b000};
    localparam logic [7:0]  R_ALT = 8'b1000_0010;  // SUB and SRA

    logic    clk;
    logic    reset_n;
    logic    in_valid;
    logic    in_ready;
    instr_t  in_instr;
    logic    out_valid;
    logic    out_ready;
    retire_t out_retire;
    logic    idle;
    logic    random_ready;
    int      cycle_count;

    word_t   model_regs [NUM_REGS];  // Architectural state in program order
    retire_t expected_q [$];

    alu_core_top u_dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_instr   (in_instr),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_retire (out_retire),
        .idle       (idle)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ========================================================================
    // Reference model and encoders
    // ========================================================================
    function automatic instr_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPCODE_OP};
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd);
        return {imm, rs1, f3, rd, OPCODE_OP_IMM};
    endfunction

    function automatic retire_t predict(input instr_t ins);
        retire_t    rec;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       is_op;
        logic       alt;
        logic       ok;
        word_t      a;
        word_t      b;
        word_t      fill;
        f3    = ins[14:12];
        f7    = ins[31:25];
        is_op = (ins[6:0] == OPCODE_OP);
        alt   = (f7 == FUNCT7_ALT);
        a     = model_regs[ins[19:15]];
        b     = is_op ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        fill  = a[XLEN-1] ? ~({XLEN{1'b1}} >> b[4:0]) : '0;  // Sign bits for SRA
        ok    = is_op || (ins[6:0] == OPCODE_OP_IMM);
        if (is_op && f7 != FUNCT7_BASE && !(alt && (f3 == 3'b000 || f3 == 3'b101))) begin
            ok = 1'b0;
        end
        if (!is_op && f3 == 3'b001 && f7 != FUNCT7_BASE) begin
            ok = 1'b0;
        end
        if (!is_op && f3 == 3'b101 && f7 != FUNCT7_BASE && !alt) begin
            ok = 1'b0;
        end
        rec.value = '0;
        case (f3)
            3'b000:  rec.value = (is_op && alt) ? a - b : a + b;
            3'b100:  rec.value = a ^ b;
            3'b110:  rec.value = a | b;
            3'b111:  rec.value = a & b;
            3'b001:  rec.value = a << b[4:0];
            3'b101:  rec.value = alt ? ((a >> b[4:0]) | fill) : (a >> b[4:0]);
            default: ok = 1'b0;  // SLT and SLTU forms
        endcase
        rec.rd        = ins[11:7];
        rec.reg_write = ok;
        rec.illegal   = !ok;
        return rec;
    endfunction

    function automatic instr_t random_legal();
        logic [2:0] f3;
        logic [6:0] f7;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        f3  = 3'($urandom);
        rd  = reg_addr_t'($urandom);
        rs1 = reg_addr_t'($urandom);
        rs2 = reg_addr_t'($urandom);
        if (f3 == 3'b010 || f3 == 3'b011) begin
            f3 = 3'b000;
        end
        f7 = ((f3 == 3'b000 || f3 == 3'b101) && ($urandom % 2 == 1)) ? FUNCT7_ALT : FUNCT7_BASE;
        if ($urandom % 2 == 1) begin
            return enc_r(f7, rs2, rs1, f3, rd);
        end
        if (f3 == 3'b001 || f3 == 3'b101) begin
            return enc_i({f7, rs2}, rs1, f3, rd);  // Shift amount in rs2 field
        end
        return enc_i(12'($urandom), rs1, f3, rd);
    endfunction

    // ========================================================================
    // Compare tasks and failure exit
    // ========================================================================
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_retire(input retire_t got, input retire_t want);
        logic bad;
        bad = (got.rd !== want.rd) || (got.reg_write !== want.reg_write) ||
              (got.illegal !== want.illegal) ||
              (!want.illegal && (got.value !== want.value));  // Illegal value is don't care
        if (bad) begin
            abort_run({$sformatf("Mismatch at %0t: retire rd=%0d value=%h we=%b ill=%b",
                                 $time, got.rd, got.value, got.reg_write, got.illegal),
                       $sformatf(", expected rd=%0d value=%h we=%b ill=%b",
                                 want.rd, want.value, want.reg_write, want.illegal)});
        end
    endtask

    task automatic check_ready(input logic want_ready, input logic want_valid,
                               input logic want_idle);
        if (in_ready !== want_ready || out_valid !== want_valid || idle !== want_idle) begin
            abort_run({$sformatf("Mismatch at %0t: in_ready=%b out_valid=%b idle=%b",
                                 $time, in_ready, out_valid, idle),
                       $sformatf(", expected %b %b %b",
                                 want_ready, want_valid, want_idle)});
        end
    endtask

    // Retire monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (reset_n && out_valid && idle) begin
            abort_run("idle was high while a retire record waited at the output");
        end
        if (reset_n && out_valid && out_ready) begin
            if (expected_q.size() == 0) begin
                abort_run("A retire record came out with no instruction outstanding");
            end else begin
                check_retire(out_retire, expected_q.pop_front());
            end
        end
    end

    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            out_ready <= random_ready ? 1'($urandom) : 1'b1;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        abort_run($sformatf("Timeout: the run was still going after %0d cycles",
                            TIMEOUT_CYCLES));
    end

    // ========================================================================
    // Stimulus tasks, called on a rising edge
    // ========================================================================
    task automatic send(input instr_t ins);
        retire_t want;
        logic    ready;
        want = predict(ins);
        if (want.reg_write && want.rd != '0) begin
            model_regs[want.rd] = want.value;
        end
        expected_q.push_back(want);
        in_valid <= 1'b1;
        in_instr <= ins;
        do begin
            @(negedge clk);
            ready = in_ready;
            @(posedge clk);
        end while (!ready);
    endtask

    task automatic drain();
        in_valid <= 1'b0;
        do @(negedge clk); while (expected_q.size() != 0 || !idle);
        @(posedge clk);
    endtask

    // Builds a full word in rd from 10, 11 and 11 bit chunks
    task automatic load_reg(input reg_addr_t rd, input word_t v);
        send(enc_i({2'b00, v[31:22]}, 5'd0, 3'b000, rd));
        send(enc_i(12'd11, rd, 3'b001, rd));
        send(enc_i({1'b0, v[21:11]}, rd, 3'b110, rd));
        send(enc_i(12'd11, rd, 3'b001, rd));
        send(enc_i({1'b0, v[10:0]}, rd, 3'b110, rd));
    endtask

    task automatic read_all_regs();
        for (int i = 0; i < NUM_REGS; i++) begin
            send(enc_i(12'd0, reg_addr_t'(i), 3'b000, 5'd0));  // ADDI x0, xi, 0
        end
        drain();
    endtask

    task automatic test_imm_ops();
        send(enc_i(12'hf9c, 5'd0, 3'b000, 5'd1));   // -100
        send(enc_i(12'h7ff, 5'd0, 3'b000, 5'd2));
        send(enc_i(12'h800, 5'd0, 3'b000, 5'd3));   // -2048
        send(enc_i(12'hffb, 5'd1, 3'b000, 5'd4));
        send(enc_i(12'hff0, 5'd2, 3'b111, 5'd5));   // ANDI
        send(enc_i(12'h0f0, 5'd1, 3'b110, 5'd6));   // ORI
        send(enc_i(12'hfff, 5'd3, 3'b100, 5'd7));   // XORI as NOT
        send(enc_i(12'h003, 5'd1, 3'b001, 5'd8));   // SLLI
        send(enc_i(12'h004, 5'd1, 3'b101, 5'd9));   // SRLI
        send(enc_i(12'h404, 5'd1, 3'b101, 5'd10));  // SRAI
        send(enc_i(12'h41f, 5'd3, 3'b101, 5'd11));
        send(enc_i(12'h01f, 5'd2, 3'b001, 5'd11));
        drain();
    endtask

    task automatic test_reg_ops();
        word_t a;
        word_t b;
        repeat (8) begin
            a = $urandom;
            b = $urandom;
            load_reg(5'd12, a);
            load_reg(5'd13, b);
            for (int k = 0; k < 8; k++) begin
                send(enc_r(R_ALT[k] ? FUNCT7_ALT : FUNCT7_BASE, 5'd13, 5'd12,
                           R_F3[k*3 +: 3], reg_addr_t'(14 + k)));
            end
        end
        drain();
    endtask

    task automatic test_chains();
        load_reg(5'd22, 32'h8000_0010);
        repeat (6) send(enc_i(12'd3, 5'd22, 3'b000, 5'd22));
        send(enc_r(FUNCT7_BASE, 5'd22, 5'd22, 3'b000, 5'd23));
        send(enc_r(FUNCT7_ALT, 5'd22, 5'd23, 3'b000, 5'd24));
        send(enc_i(12'h055, 5'd24, 3'b000, 5'd0));           // Result to x0
        send(enc_r(FUNCT7_BASE, 5'd0, 5'd24, 3'b000, 5'd25));  // x0 must read zero
        drain();
    endtask

    task automatic test_backpressure();
        random_ready <= 1'b1;
        repeat (200) send(random_legal());
        drain();
        random_ready <= 1'b0;
    endtask

    task automatic test_illegal();
        send(32'h0000_2083);                                  // LW
        send(enc_r(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd4));    // MUL
        send(enc_r(FUNCT7_BASE, 5'd2, 5'd1, 3'b010, 5'd4));   // SLT
        send(enc_r(FUNCT7_ALT, 5'd2, 5'd1, 3'b100, 5'd4));
        send(enc_i(12'h401, 5'd1, 3'b001, 5'd4));
        send(enc_i(12'h201, 5'd1, 3'b101, 5'd4));
        send(enc_i(12'h005, 5'd1, 3'b011, 5'd4));             // SLTIU
        drain();
        read_all_regs();
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        void'($urandom(SEED));
        in_valid     = 1'b0;
        in_instr     = '0;
        random_ready = 1'b0;
        reset_n      = 1'b1;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        #1 reset_n = 1'b0;
        repeat (15) @(posedge clk);
        @(negedge clk);
        check_ready(1'b0, 1'b0, 1'b1);
        @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_ready(1'b0, 1'b0, 1'b1);
        @(posedge clk);
        @(negedge clk);
        check_ready(1'b1, 1'b0, 1'b1);
        @(posedge clk);

        read_all_regs();
        test_imm_ops();
        test_reg_ops();
        test_chains();
        test_backpressure();
        test_illegal();

        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: flist.f
design/core_pkg.sv
design/instr_decoder.sv
design/reg_file.sv
design/alu.sv
design/pipe_stage.sv
design/hazard_control.sv
design/alu_core_top.sv
verif/alu_core_assertions.sv
verif/tb_alu_core.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run; the exit status is the simulator's
verilator --binary --timing --assert -f flist.f --top-module tb_alu_core -o sim_alu_core \
    && ./obj_dir/sim_alu_core \
    || exit 1
